/* common/kp_macros.svh */
`ifndef KP_MACROS_SVH
`define KP_MACROS_SVH

// Blur layers per column beat
`define KP_LAYERS 5

// |DoG| must exceed this to count as a keypoint
`define KP_CONTRAST_TH 4

// Principal curvature ratio limit for the edge test
`define KP_EDGE_R 10

// Keypoint number width, 2K keypoints before wrap
`define KP_NUM_W 11

`endif

/* common/kp_pkg.sv */
`default_nettype none
`include "kp_macros.svh"

package kp_pkg;

  typedef logic [7:0]          pix_t;     // Blurred pixel
  typedef logic signed [8:0]   dog_t;     // Layer k+1 minus layer k
  typedef logic [8:0]          row_t;
  typedef logic [9:0]          col_t;
  typedef logic [`KP_NUM_W-1:0] kp_num_t; // Wraps around

  // Three vertically adjacent pixels of one layer
  typedef struct packed {
    pix_t up;
    pix_t mid;
    pix_t lo;
  } pix_trio_t;

  typedef struct packed {
    pix_trio_t [`KP_LAYERS-1:0] layer;
    row_t                       row;  // Middle row
    col_t                       col;
  } col_beat_t;

  // Row-major 3x3, px[4] is the centre
  typedef struct packed {
    dog_t [8:0] px;
  } dog_win_t;

  typedef struct packed {
    row_t row;
    col_t col;
  } cand_t;

  typedef struct packed {
    dog_win_t [`KP_LAYERS-2:0] dog;
    cand_t                     ctr;  // Window centre
  } win_set_t;

  typedef struct packed {
    cand_t   pos;
    logic    scale;  // Lane that found it
    kp_num_t num;
  } kp_t;

endpackage

`default_nettype wire

/* hw/scale_window.sv */
`default_nettype none
`include "kp_macros.svh"

module scale_window (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              in_valid,
  input  wire kp_pkg::col_beat_t in_beat,
  input  wire logic [1:0]        lane_ready,
  output logic                   in_ready,
  output logic                   win_valid,
  output kp_pkg::win_set_t       win_set
);
  import kp_pkg::*;

  localparam int NUM_DOG = `KP_LAYERS - 1;

  pix_trio_t [`KP_LAYERS-1:0] col_d1;  // Previous column
  pix_trio_t [`KP_LAYERS-1:0] col_d2;  // Two columns back
  pix_trio_t [`KP_LAYERS-1:0] cols [3];
  dog_win_t [NUM_DOG-1:0]     dog_nxt;
  logic [1:0]                 fill;
  logic                       accept;
  logic                       consume;
  logic                       win_load;

  function automatic dog_t dog_of(pix_t hi_pix, pix_t lo_pix);
    return dog_t'({1'b0, hi_pix}) - dog_t'({1'b0, lo_pix});
  endfunction

  assign consume  = win_valid && (&lane_ready);  // Both lanes take it together
  assign in_ready = !win_valid || consume;
  assign accept   = in_valid && in_ready;
  assign win_load = accept && (in_beat.col != '0) && (fill == 2'd2);

  // Left, centre, right
  assign cols[0] = col_d2;
  assign cols[1] = col_d1;
  assign cols[2] = in_beat.layer;

  always_comb begin
    for (int k = 0; k < NUM_DOG; k++) begin
      for (int c = 0; c < 3; c++) begin
        dog_nxt[k].px[c]     = dog_of(cols[c][k+1].up, cols[c][k].up);
        dog_nxt[k].px[3 + c] = dog_of(cols[c][k+1].mid, cols[c][k].mid);
        dog_nxt[k].px[6 + c] = dog_of(cols[c][k+1].lo, cols[c][k].lo);
      end
    end
  end

  // Columns seen since the last column 0, saturates at two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fill <= 2'd0;
    end else if (accept) begin
      if (in_beat.col == '0) begin
        fill <= 2'd1;
      end else if (fill != 2'd2) begin
        fill <= fill + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      col_d2 <= col_d1;
      col_d1 <= in_beat.layer;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_valid <= 1'b0;
    end else if (win_load) begin
      win_valid <= 1'b1;
    end else if (consume) begin
      win_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (win_load) begin
      win_set.dog     <= dog_nxt;
      win_set.ctr.row <= in_beat.row;
      win_set.ctr.col <= in_beat.col - 1'b1;  // Centre lags one column
    end
  end

endmodule

`default_nettype wire

/* detect/edge_contrast.sv */
`default_nettype none
`include "kp_macros.svh"

module edge_contrast (
  input  wire kp_pkg::dog_win_t win,
  output logic                  edge_ok
);

  // Sized for DoG inputs of +/-255
  logic signed [11:0] dxx;
  logic signed [11:0] dyy;
  logic signed [11:0] dxy4;  // Four times the mixed derivative
  logic signed [12:0] trace;
  logic signed [39:0] det16;
  logic signed [39:0] trace_term;
  logic signed [39:0] det_term;

  assign dxx   = win.px[3] + win.px[5] - 2 * win.px[4];
  assign dyy   = win.px[1] + win.px[7] - 2 * win.px[4];
  assign dxy4  = win.px[8] + win.px[0] - win.px[2] - win.px[6];
  assign trace = dxx + dyy;

  // Cross term is 4*dxy, so determinant and trace^2 both carry a factor of 16
  assign det16 = 16 * dxx * dyy - dxy4 * dxy4;

  // r*tr^2 < (r+1)^2*det, with det > 0
  assign trace_term = `KP_EDGE_R * 16 * trace * trace;
  assign det_term   = (`KP_EDGE_R + 1) * (`KP_EDGE_R + 1) * det16;

  assign edge_ok = (det16 > 0) && (trace_term < det_term);

endmodule

`default_nettype wire

/* detect/extrema_lane.sv */
`default_nettype none
`include "kp_macros.svh"

module extrema_lane (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             win_valid,  // Window is being consumed
  input  wire kp_pkg::dog_win_t win_lo,
  input  wire kp_pkg::dog_win_t win_mid,
  input  wire kp_pkg::dog_win_t win_hi,
  input  wire kp_pkg::cand_t    ctr,
  input  wire logic             take,
  output logic                  lane_ready,
  output logic                  cand_valid,
  output kp_pkg::cand_t         cand
);
  import kp_pkg::*;

  dog_t centre;
  logic gt_all;
  logic lt_all;
  logic contrast_ok;
  logic edge_ok;
  logic keep;

  assign centre = win_mid.px[4];

  // Strict extremum over the 26 neighbours
  always_comb begin
    gt_all = 1'b1;
    lt_all = 1'b1;
    for (int i = 0; i < 9; i++) begin
      gt_all &= (centre > win_lo.px[i]) && (centre > win_hi.px[i]);
      lt_all &= (centre < win_lo.px[i]) && (centre < win_hi.px[i]);
      if (i != 4) begin
        gt_all &= (centre > win_mid.px[i]);
        lt_all &= (centre < win_mid.px[i]);
      end
    end
  end

  assign contrast_ok = (centre > `KP_CONTRAST_TH) || (centre < -(`KP_CONTRAST_TH));

  edge_contrast u_edge (
    .win     (win_mid),
    .edge_ok (edge_ok)
  );

  assign keep = (gt_all || lt_all) && contrast_ok && edge_ok;

  assign lane_ready = !cand_valid || take;

  // A consumed window implies this lane was ready, so overwrite is safe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cand_valid <= 1'b0;
    end else if (win_valid) begin
      cand_valid <= keep;
    end else if (take) begin
      cand_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (win_valid && keep) begin
      cand <= ctr;
    end
  end

endmodule

`default_nettype wire

/* hw/keypoint_merge.sv */
`default_nettype none

module keypoint_merge (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire logic [1:0]    cand_valid,
  input  wire kp_pkg::cand_t cand0,
  input  wire kp_pkg::cand_t cand1,
  input  wire logic          out_ready,
  output logic [1:0]         take,
  output logic               out_valid,
  output kp_pkg::kp_t        out_kp
);
  import kp_pkg::*;

  typedef enum logic {
    PRI_LANE0,
    PRI_LANE1
  } pri_e;

  pri_e    pri;       // Lane that wins the next tie
  cand_t   out_pos;
  logic    out_scale;
  kp_num_t kp_cnt;    // Output transfers so far
  logic    out_free;

  assign out_free = !out_valid || out_ready;

  always_comb begin
    take = 2'b00;
    if (out_free) begin
      if (cand_valid[0] && (!cand_valid[1] || pri == PRI_LANE0)) begin
        take[0] = 1'b1;
      end else if (cand_valid[1]) begin
        take[1] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      pri       <= PRI_LANE0;
      kp_cnt    <= '0;
    end else begin
      if (|take) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
      if (take[0]) begin
        pri <= PRI_LANE1;
      end else if (take[1]) begin
        pri <= PRI_LANE0;
      end
      if (out_valid && out_ready) begin
        kp_cnt <= kp_cnt + 1'b1;  // Wraps
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take[0]) begin
      out_pos   <= cand0;
      out_scale <= 1'b0;
    end else if (take[1]) begin
      out_pos   <= cand1;
      out_scale <= 1'b1;
    end
  end

  // Number only moves on transfer, so it holds while stalled
  assign out_kp = '{pos: out_pos, scale: out_scale, num: kp_cnt};

endmodule

`default_nettype wire

/* hw/keypoint_detect_top.sv */
`default_nettype none

module keypoint_detect_top (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              in_valid,
  input  wire kp_pkg::col_beat_t in_beat,
  output logic                   in_ready,
  output logic                   out_valid,
  output kp_pkg::kp_t            out_kp,
  input  wire logic              out_ready
);
  import kp_pkg::*;

  win_set_t   win_set;
  logic       win_valid;
  logic       win_fire;
  logic [1:0] lane_ready;
  logic [1:0] cand_valid;
  logic [1:0] take;
  cand_t      cand0;
  cand_t      cand1;

  // Window moves only when both lanes accept it
  assign win_fire = win_valid && (&lane_ready);

  scale_window u_window (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_beat    (in_beat),
    .lane_ready (lane_ready),
    .in_ready   (in_ready),
    .win_valid  (win_valid),
    .win_set    (win_set)
  );

  extrema_lane u_lane0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .win_valid  (win_fire),
    .win_lo     (win_set.dog[0]),
    .win_mid    (win_set.dog[1]),
    .win_hi     (win_set.dog[2]),
    .ctr        (win_set.ctr),
    .take       (take[0]),
    .lane_ready (lane_ready[0]),
    .cand_valid (cand_valid[0]),
    .cand       (cand0)
  );

  extrema_lane u_lane1 (
    .clk        (clk),
    .rst_n      (rst_n),
    .win_valid  (win_fire),
    .win_lo     (win_set.dog[1]),
    .win_mid    (win_set.dog[2]),
    .win_hi     (win_set.dog[3]),
    .ctr        (win_set.ctr),
    .take       (take[1]),
    .lane_ready (lane_ready[1]),
    .cand_valid (cand_valid[1]),
    .cand       (cand1)
  );

  keypoint_merge u_merge (
    .clk        (clk),
    .rst_n      (rst_n),
    .cand_valid (cand_valid),
    .cand0      (cand0),
    .cand1      (cand1),
    .out_ready  (out_ready),
    .take       (take),
    .out_valid  (out_valid),
    .out_kp     (out_kp)
  );

endmodule

`default_nettype wire

/* sim/keypoint_detect_props.sv */
`default_nettype none

module keypoint_detect_props (
  input wire logic          clk,
  input wire logic          rst_n,
  input wire logic          out_valid,
  input wire logic          out_ready,
  input wire kp_pkg::kp_t   out_kp,
  input wire logic [1:0]    cand_valid,
  input wire logic [1:0]    take,
  input wire kp_pkg::cand_t cand0,
  input wire kp_pkg::cand_t cand1
);

  out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_kp))
    else $error("output keypoint changed or vanished while stalled");

  // Lane registers hold until the merge takes them
  lane0_hold: assert property (@(posedge clk) disable iff (!rst_n)
    cand_valid[0] && !take[0] |=> cand_valid[0] && $stable(cand0))
    else $error("lane 0 candidate changed before it was taken");

  lane1_hold: assert property (@(posedge clk) disable iff (!rst_n)
    cand_valid[1] && !take[1] |=> cand_valid[1] && $stable(cand1))
    else $error("lane 1 candidate changed before it was taken");

  one_take: assert property (@(posedge clk) disable iff (!rst_n) !(&take))
    else $error("merge took from both lanes in one cycle");

  reset_idle: assert property (@(posedge clk) !rst_n |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

endmodule

bind keypoint_detect_top keypoint_detect_props u_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .out_valid  (out_valid),
  .out_ready  (out_ready),
  .out_kp     (out_kp),
  .cand_valid (cand_valid),
  .take       (take),
  .cand0      (cand0),
  .cand1      (cand1)
);

`default_nettype wire

/* sim/keypoint_detect_tb.sv */
`default_nettype none
`include "kp_macros.svh"

module keypoint_detect_tb;
  import kp_pkg::*;

  localparam int DRV_DLY     = 10;
  localparam int RAND_ROWS   = 5;
  localparam int RAND_COLS   = 24;
  localparam int N_BEATS     = 15 + RAND_ROWS * RAND_COLS;
  localparam int CYCLE_LIMIT = 4 * N_BEATS + 200;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        in_valid;
  col_beat_t   in_beat;
  logic        in_ready;
  logic        out_valid;
  kp_t         out_kp;
  logic        out_ready;
  logic [15:0] pix_lfsr = 16'd3;
  logic [15:0] bp_lfsr  = 16'd3;
  logic        bp_en    = 1'b0;  // Random out_ready
  cand_t       exp_q0 [$];
  cand_t       exp_q1 [$];
  col_beat_t   hist [2];         // Newest first
  int          fill_cnt = 0;
  int          n_exp [2] = '{0, 0};  // Kept by the reference
  int          n_out [2] = '{0, 0};
  int          kp_seen = 0;
  int          cycles = 0;

  keypoint_detect_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_beat   (in_beat),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_kp    (out_kp),
    .out_ready (out_ready)
  );

  always #50 clk = ~clk;

  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [7:0] rand_pix();
    logic [7:0] v;
    for (int i = 0; i < 8; i++) begin
      pix_lfsr = lfsr_next(pix_lfsr);
      v[i] = pix_lfsr[0];
    end
    return v;
  endfunction

  task automatic stop_on_error(string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      stop_on_error($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
    end
  endtask

  function automatic int pix_at(col_beat_t b, int lyr, int r);
    case (r)
      0: return int'(b.layer[lyr].up);
      1: return int'(b.layer[lyr].mid);
      default: return int'(b.layer[lyr].lo);
    endcase
  endfunction

  // Whether a lane keeps the centre of columns b0, b1, b2
  function automatic bit lane_keeps(col_beat_t b0, col_beat_t b1, col_beat_t b2, int lane);
    int        d [3][3][3];  // DoG layer, row, column
    col_beat_t cols [3];
    int        c;
    int        dxx;
    int        dyy;
    int        dxy;
    bit        is_max;
    bit        is_min;
    longint    det16;
    cols[0] = b0;
    cols[1] = b1;
    cols[2] = b2;
    for (int l = 0; l < 3; l++)
      for (int r = 0; r < 3; r++)
        for (int x = 0; x < 3; x++)
          d[l][r][x] = pix_at(cols[x], lane + l + 1, r) - pix_at(cols[x], lane + l, r);
    c      = d[1][1][1];
    is_max = 1'b1;
    is_min = 1'b1;
    for (int l = 0; l < 3; l++)
      for (int r = 0; r < 3; r++)
        for (int x = 0; x < 3; x++)
          if (!(l == 1 && r == 1 && x == 1)) begin
            is_max &= c > d[l][r][x];
            is_min &= c < d[l][r][x];
          end
    dxx   = d[1][1][0] + d[1][1][2] - 2 * c;
    dyy   = d[1][0][1] + d[1][2][1] - 2 * c;
    dxy   = d[1][2][2] + d[1][0][0] - d[1][0][2] - d[1][2][0];
    det16 = 16 * longint'(dxx) * dyy - longint'(dxy) * dxy;
    return (is_max || is_min) && (c > `KP_CONTRAST_TH || c < -`KP_CONTRAST_TH) && det16 > 0 &&
           `KP_EDGE_R * 16 * longint'(dxx + dyy) * (dxx + dyy) <
           (`KP_EDGE_R + 1) * (`KP_EDGE_R + 1) * det16;
  endfunction

  // Called a drive delay after a rising edge, returns the same way
  task automatic send_beat(col_beat_t b);
    cand_t ctr;
    ctr.row  = b.row;
    ctr.col  = b.col - 1'b1;
    fill_cnt = (b.col == '0) ? 1 : fill_cnt + 1;
    if (fill_cnt >= 3) begin
      if (lane_keeps(hist[1], hist[0], b, 0)) begin
        exp_q0.push_back(ctr);
        n_exp[0]++;
      end
      if (lane_keeps(hist[1], hist[0], b, 1)) begin
        exp_q1.push_back(ctr);
        n_exp[1]++;
      end
    end
    hist[1]  = hist[0];
    hist[0]  = b;
    in_valid = 1'b1;
    in_beat  = b;
    @(negedge clk);
    while (!in_ready) @(negedge clk);
    @(posedge clk);
    #DRV_DLY;
    in_valid = 1'b0;
  endtask

  // Flat 3-column patch with one layer bent at the centre column
  task automatic send_patch(row_t row, int lyr, int d_up, int d_mid, int d_lo);
    col_beat_t b;
    for (int c = 0; c < 3; c++) begin
      b = '0;
      for (int k = 0; k < `KP_LAYERS; k++) begin
        b.layer[k] = '{up: 8'd100, mid: 8'd100, lo: 8'd100};
      end
      if (c == 1) begin
        b.layer[lyr] = '{up: pix_t'(100 + d_up), mid: pix_t'(100 + d_mid),
                         lo: pix_t'(100 + d_lo)};
      end
      b.row = row;
      b.col = col_t'(c);
      send_beat(b);
    end
  endtask

  task automatic drain_and_count(int n0, int n1);
    while (exp_q0.size() != 0 || exp_q1.size() != 0) @(negedge clk);
    repeat (8) @(negedge clk);  // Room for a stray output
    check("lane 0 keypoint count", n0, n_out[0]);
    check("lane 1 keypoint count", n1, n_out[1]);
    @(posedge clk);
    #DRV_DLY;
  endtask

  always @(posedge clk) begin
    #DRV_DLY;
    if (bp_en) begin
      bp_lfsr   = lfsr_next(lfsr_next(bp_lfsr));
      out_ready = |bp_lfsr[1:0];
    end else begin
      out_ready = 1'b1;
    end
  end

  always @(negedge clk) begin : compare
    cand_t exp_pos;
    if (rst_n && out_valid && out_ready) begin
      if ((out_kp.scale ? exp_q1.size() : exp_q0.size()) == 0) begin
        stop_on_error($sformatf("lane %0d gave a keypoint nobody expected", out_kp.scale));
      end else begin
        if (out_kp.scale) begin
          exp_pos = exp_q1.pop_front();
        end else begin
          exp_pos = exp_q0.pop_front();
        end
        check("out_kp.pos.row", exp_pos.row, out_kp.pos.row);
        check("out_kp.pos.col", exp_pos.col, out_kp.pos.col);
        check("out_kp.num", kp_seen % (1 << `KP_NUM_W), out_kp.num);
        n_out[out_kp.scale]++;
        kp_seen++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      stop_on_error("timeout, the run went past its cycle limit");
    end
  end

  initial begin
    col_beat_t b;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_beat   = '0;
    out_ready = 1'b1;
    hist[0]   = '0;
    hist[1]   = '0;
    repeat (2) @(posedge clk);
    #DRV_DLY;
    rst_n = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check("in_ready", 1, in_ready);
      check("out_valid", 0, out_valid);
    end
    @(posedge clk);
    #DRV_DLY;
    send_patch(9'd20, 1, 0, -20, 0);  // Max in DoG 1, lane 0 only
    drain_and_count(1, 0);
    send_patch(9'd21, 3, 0, -20, 0);  // Min in DoG 2, lane 1 only
    drain_and_count(1, 1);
    send_patch(9'd22, 1, 0, -4, 0);   // At the contrast threshold
    drain_and_count(1, 1);
    send_patch(9'd23, 1, -19, -20, -19);  // Vertical ridge
    drain_and_count(1, 1);
    send_patch(9'd24, 2, 0, 20, 0);   // Extremum in both lanes
    drain_and_count(2, 2);
    bp_en = 1'b1;
    for (int r = 0; r < RAND_ROWS; r++) begin
      for (int c = 0; c < RAND_COLS; c++) begin
        for (int k = 0; k < `KP_LAYERS; k++) begin
          b.layer[k].up  = rand_pix();
          b.layer[k].mid = rand_pix();
          b.layer[k].lo  = rand_pix();
        end
        b.row = row_t'(100 + r);
        b.col = col_t'(c);
        send_beat(b);
      end
    end
    drain_and_count(n_exp[0], n_exp[1]);
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+common
common/kp_pkg.sv
hw/scale_window.sv
detect/edge_contrast.sv
detect/extrema_lane.sv
hw/keypoint_merge.sv
hw/keypoint_detect_top.sv
sim/keypoint_detect_props.sv
sim/keypoint_detect_tb.sv
